/* verilog.f */
hw/cdb_pkg.sv
hw/issue_stage.sv
hw/add_mul_pipe.sv
hw/divider.sv
hw/cdb_arbiter.sv
hw/cdb_core.sv
sim/tb_clock.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the log
rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_top -f verilog.f > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1

/* sim/tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top import cdb_pkg::*; ();
	localparam int RESET_CYCLES  = 5;
	localparam int DRIVE_DELAY   = 2;
	localparam int RANDOM_OPS    = 400;
	localparam int DIRECTED_OPS  = 16;
	localparam int TOTAL_OPS     = RANDOM_OPS + DIRECTED_OPS;
	localparam int WATCHDOG_CYC  = TOTAL_OPS * (DIV_LAT + 10) + RESET_CYCLES;
	localparam int NUM_TAGS      = 16;
	// last op may wait behind a divide, then run a full divide
	localparam int DRAIN_CYC     = 2 * DIV_LAT + 10;

	logic  clk;
	logic  arst_n;
	logic  in_valid;
	logic  in_ready;
	op_t   in_op;
	data_t in_a;
	data_t in_b;
	tag_t  in_tag;
	logic  cdb_valid;
	tag_t  cdb_tag;
	data_t cdb_data;

	// scoreboard, indexed by tag
	data_t exp_data [NUM_TAGS];
	int    sent_cnt [NUM_TAGS];
	int    seen_cnt [NUM_TAGS];
	int    sent_total;
	int    seen_total;
	tag_t  tag_order [$];

	int          error_count;
	int          check_count;
	logic [31:0] rng_state;

	tb_clock u_clock (
		.clk
	);

	cdb_core i_dut (
		.clk, .arst_n,
		.in_valid, .in_ready, .in_op, .in_a, .in_b, .in_tag,
		.cdb_valid, .cdb_tag, .cdb_data
	);

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// expected result from the opcode rules
	function automatic data_t ref_result(input op_t op, input data_t a, input data_t b);
		data_t r;
		case (op)
			OP_ADD: r = a + b;
			OP_SUB: r = a - b;
			OP_MUL: r = a * b;
			OP_DIV: r = (b == '0) ? '1 : a / b;
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
			error_count++;
		end
	endtask

	// called 2 ns after a rising edge, returns the same way
	task automatic send_op(input op_t op, input data_t a, input data_t b, input tag_t tag,
			output int stalls);
		logic accepted;
		stalls = 0;
		accepted = 1'b0;
		// tag is reused only once its result is back
		while (sent_cnt[tag] != seen_cnt[tag]) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		exp_data[tag] = ref_result(op, a, b);
		in_valid = 1'b1;
		in_op    = op;
		in_a     = a;
		in_b     = b;
		in_tag   = tag;
		while (!accepted) begin
			@(negedge clk);
			accepted = in_ready;
			@(posedge clk);
			#DRIVE_DELAY;
			if (!accepted) begin
				stalls++;
			end
		end
		in_valid = 1'b0;
		sent_cnt[tag] = sent_cnt[tag] + 1;
		sent_total++;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (sent_total != seen_total && waited < DRAIN_CYC) begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
		end
	endtask

	task automatic check_order(input int first_tag, input int count);
		check_value("cdb_tag count", 32'(tag_order.size()), 32'(count));
		if (tag_order.size() == count) begin
			for (int i = 0; i < count; i++) begin
				check_value("cdb_tag", 32'(tag_order[i]), 32'(first_tag + i));
			end
		end
	endtask

	//////////////////////////////
	// watchdog
	//////////////////////////////
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("timeout: not all results arrived within %0d cycles", WATCHDOG_CYC);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////
	// stimulus and checking
	//////////////////////////////
	initial begin
		int          stalls;
		logic [31:0] r;
		op_t         rop;
		data_t       ra;
		data_t       rb;
		tag_t        next_tag;

		arst_n      = 1'b0;
		in_valid    = 1'b0;
		in_op       = OP_ADD;
		in_a        = '0;
		in_b        = '0;
		in_tag      = '0;
		rng_state   = 32'hb4da1f7b;
		error_count = 0;
		check_count = 0;
		sent_total  = 0;
		seen_total  = 0;
		next_tag    = '0;
		for (int i = 0; i < NUM_TAGS; i++) begin
			exp_data[i] = '0;
			sent_cnt[i] = 0;
			seen_cnt[i] = 0;
		end

		// compare every broadcast against the scoreboard
		fork
			forever begin
				@(negedge clk);
				if (arst_n && cdb_valid) begin
					if (sent_cnt[cdb_tag] == seen_cnt[cdb_tag]) begin
						$display("ERROR: unexpected or duplicate tag %0d on the result bus",
							cdb_tag);
						error_count++;
					end else begin
						check_value("cdb_data", cdb_data, exp_data[cdb_tag]);
						seen_cnt[cdb_tag] = seen_cnt[cdb_tag] + 1;
						seen_total++;
						tag_order.push_back(cdb_tag);
					end
				end
			end
		join_none

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;

		// idle outputs after reset
		@(negedge clk);
		check_value("cdb_valid", 32'(cdb_valid), 32'd0);
		check_value("in_ready", 32'(in_ready), 32'd1);
		@(posedge clk);
		#DRIVE_DELAY;

		// one of each, sent alone
		send_op(OP_ADD, 32'hffff_ffff, 32'h0000_0002, 4'd1, stalls);
		wait_drain();
		send_op(OP_SUB, 32'h0000_0001, 32'h0000_0003, 4'd2, stalls);
		wait_drain();
		send_op(OP_MUL, 32'h1234_5678, 32'h9abc_def1, 4'd3, stalls);
		wait_drain();
		send_op(OP_DIV, 32'd1000000007, 32'd97, 4'd4, stalls);
		wait_drain();

		// divide by zero
		send_op(OP_DIV, 32'hdead_beef, 32'h0000_0000, 4'd5, stalls);
		wait_drain();

		// back to back adds, then multiplies, leave in issue order
		tag_order.delete();
		for (int i = 0; i < 4; i++) begin
			send_op(OP_ADD, next_rand(), next_rand(), tag_t'(i), stalls);
		end
		wait_drain();
		check_order(0, 4);
		tag_order.delete();
		for (int i = 4; i < 8; i++) begin
			send_op(OP_MUL, next_rand(), next_rand(), tag_t'(i), stalls);
		end
		wait_drain();
		check_order(4, 4);

		// second divide waits in the issue register
		send_op(OP_DIV, 32'hffff_ffff, 32'd7, 4'd8, stalls);
		send_op(OP_DIV, 32'd12345, 32'h0000_0010, 4'd9, stalls);
		@(negedge clk);
		check_value("in_ready", 32'(in_ready), 32'd0);
		@(posedge clk);
		#DRIVE_DELAY;
		send_op(OP_ADD, 32'd10, 32'd20, 4'd10, stalls);
		check_value("in_ready stall seen", 32'(stalls > 0), 32'd1);
		wait_drain();

		//////////////////////////////
		// random mixed stream
		//////////////////////////////
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r   = next_rand();
			rop = op_t'(r[31:30]);
			ra  = next_rand();
			rb  = next_rand();
			if (rop == OP_DIV) begin
				rb = rb >> r[20:16];
			end
			send_op(rop, ra, rb, next_tag, stalls);
			next_tag = next_tag + 4'd1;
			if (r[27:26] == 2'b00) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
		end
		wait_drain();

		// scoreboard must be empty
		check_value("outstanding", 32'(sent_total - seen_total), 32'd0);
		for (int i = 0; i < NUM_TAGS; i++) begin
			check_value("tag balance", 32'(sent_cnt[i] - seen_cnt[i]), 32'd0);
		end

		repeat (DIV_LAT) @(posedge clk);
		$display("checks: %0d, results: %0d, errors: %0d", check_count, seen_total,
			error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk
);
	// 40 ns period
	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = !clk;
	end

endmodule

`default_nettype wire

/* hw/cdb_core.sv */
`timescale 1ns/10ps
`default_nettype none

module cdb_core import cdb_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  in_valid,
	output logic  in_ready,
	input  op_t   in_op,
	input  data_t in_a,
	input  data_t in_b,
	input  tag_t  in_tag,
	output logic  cdb_valid,
	output tag_t  cdb_tag,
	output data_t cdb_data
);
	// dispatch handshake
	logic  disp_valid;
	unit_t disp_unit;
	tag_t  disp_tag;
	logic  disp_ready;

	// operands and start pulses
	op_t   op;
	data_t a;
	data_t b;
	logic  add_start;
	logic  mul_start;
	logic  div_start;

	// unit results
	data_t add_result;
	data_t mul_result;
	data_t div_result;
	logic  div_busy;

	issue_stage u_issue (
		.clk, .arst_n,
		.in_valid, .in_ready, .in_op, .in_a, .in_b, .in_tag,
		.disp_valid, .disp_unit, .disp_tag, .disp_ready,
		.op, .a, .b, .add_start, .mul_start, .div_start
	);

	add_mul_pipe u_add_mul (
		.clk, .arst_n,
		.op, .a, .b, .add_start, .mul_start,
		.add_result, .mul_result
	);

	divider u_div (
		.clk, .arst_n,
		.a, .b, .div_start,
		.div_result, .div_busy
	);

	cdb_arbiter u_arb (
		.clk, .arst_n,
		.disp_valid, .disp_unit, .disp_tag, .disp_ready,
		.div_busy,
		.add_result, .mul_result, .div_result,
		.cdb_valid, .cdb_tag, .cdb_data
	);

endmodule

`default_nettype wire

/* hw/cdb_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter import cdb_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  disp_valid,
	input  unit_t disp_unit,
	input  tag_t  disp_tag,
	output logic  disp_ready,
	input  logic  div_busy,
	input  data_t add_result,
	input  data_t mul_result,
	input  data_t div_result,
	output logic  cdb_valid,
	output tag_t  cdb_tag,
	output data_t cdb_data
);
	// reservation chain, slot 0 is the next bus cycle
	logic [SLOT_DEPTH-1:0] slot_valid;
	tag_t                  slot_tag  [SLOT_DEPTH];
	unit_t                 slot_unit [SLOT_DEPTH];

	logic [SLOT_DEPTH-1:0] slot_valid_nxt;
	tag_t                  slot_tag_nxt  [SLOT_DEPTH];
	unit_t                 slot_unit_nxt [SLOT_DEPTH];

	logic      disp_fire;
	slot_idx_t book_idx;
	data_t     bus_data;

	//////////////////////////////
	// dispatch check
	//////////////////////////////
	// slot[lat] shifts into slot[lat-1] on the dispatch edge
	always_comb begin
		case (disp_unit)
			UNIT_ADD_SUB: disp_ready = !slot_valid[ADD_LAT];
			UNIT_MUL:     disp_ready = !slot_valid[MUL_LAT];
			// nothing is ever booked beyond the divide latency
			default:      disp_ready = !div_busy;
		endcase
	end

	assign disp_fire = disp_valid && disp_ready;

	always_comb begin
		case (disp_unit)
			UNIT_ADD_SUB: book_idx = slot_idx_t'(ADD_LAT - 1);
			UNIT_MUL:     book_idx = slot_idx_t'(MUL_LAT - 1);
			default:      book_idx = slot_idx_t'(DIV_LAT - 1);
		endcase
	end

	//////////////////////////////
	// shift and book
	//////////////////////////////
	always_comb begin
		slot_valid_nxt = slot_valid >> 1;
		for (int i = 0; i < SLOT_DEPTH - 1; i++) begin
			slot_tag_nxt[i]  = slot_tag[i+1];
			slot_unit_nxt[i] = slot_unit[i+1];
		end
		slot_tag_nxt[SLOT_DEPTH-1]  = slot_tag[SLOT_DEPTH-1];
		slot_unit_nxt[SLOT_DEPTH-1] = slot_unit[SLOT_DEPTH-1];
		if (disp_fire) begin
			slot_valid_nxt[book_idx] = 1'b1;
			slot_tag_nxt[book_idx]   = disp_tag;
			slot_unit_nxt[book_idx]  = disp_unit;
		end
	end

	// result of the unit that owns slot 0
	always_comb begin
		case (slot_unit[0])
			UNIT_ADD_SUB: bus_data = add_result;
			UNIT_MUL:     bus_data = mul_result;
			default:      bus_data = div_result;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= '0;
			cdb_valid  <= 1'b0;
		end else begin
			slot_valid <= slot_valid_nxt;
			cdb_valid  <= slot_valid[0];
		end
	end

	always_ff @(posedge clk) begin
		slot_tag  <= slot_tag_nxt;
		slot_unit <= slot_unit_nxt;
		cdb_tag   <= slot_tag[0];
		cdb_data  <= bus_data;
	end

endmodule

`default_nettype wire

/* hw/divider.sv */
`timescale 1ns/10ps
`default_nettype none

module divider import cdb_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  data_t a,
	input  data_t b,
	input  logic  div_start,
	output data_t div_result,
	output logic  div_busy
);
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		ITER,
		DONE
	} div_state_t;

	div_state_t state;
	div_cnt_t   cnt;

	data_t dividend;
	data_t divisor;
	data_t rem;
	data_t quo;

	logic [DATA_W:0]   rem_shift;
	logic [DATA_W+1:0] diff;
	logic              borrow;

	// trial subtract of the shifted partial remainder
	assign rem_shift = {rem, quo[DATA_W-1]};
	assign diff      = {1'b0, rem_shift} - {2'b00, divisor};
	assign borrow    = diff[DATA_W+1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (div_start) begin
						state <= LOAD;
					end
				end
				LOAD: begin
					cnt   <= '0;
					state <= ITER;
				end
				ITER: begin
					cnt <= cnt + 1'b1;
					if (cnt == div_cnt_t'(DIV_ITERS - 1)) begin
						state <= DONE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (div_start) begin
					dividend <= a;
					divisor  <= b;
				end
			end
			LOAD: begin
				rem <= '0;
				quo <= dividend;
			end
			ITER: begin
				// restore on borrow; zero divisor never borrows, so all ones
				rem <= borrow ? rem_shift[DATA_W-1:0] : diff[DATA_W-1:0];
				quo <= {quo[DATA_W-2:0], !borrow};
			end
			default: ;
		endcase
	end

	assign div_result = quo;
	assign div_busy   = (state != IDLE);

endmodule

`default_nettype wire

/* hw/add_mul_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module add_mul_pipe import cdb_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  op_t   op,
	input  data_t a,
	input  data_t b,
	input  logic  add_start,
	input  logic  mul_start,
	output data_t add_result,
	output data_t mul_result
);
	// add/sub stage 1
	data_t add_a;
	data_t add_b;
	logic  add_sub;

	// multiplier stages 1 to 3
	data_t             mul_a;
	data_t             mul_b;
	data_t             pp_lo;
	logic [HALF_W-1:0] pp_hi;
	data_t             mul_sum;

	data_t             prod_lo;
	logic [HALF_W-1:0] prod_hi;

	// only the low half of a reaches the low word through the high partial
	assign prod_lo = mul_a * data_t'(mul_b[HALF_W-1:0]);
	assign prod_hi = mul_a[HALF_W-1:0] * mul_b[DATA_W-1:HALF_W];

	//////////////////////////////
	// add/sub, 2 stages
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			add_a      <= '0;
			add_b      <= '0;
			add_sub    <= 1'b0;
			add_result <= '0;
		end else begin
			if (add_start) begin
				add_a   <= a;
				add_b   <= b;
				add_sub <= (op == OP_SUB);
			end
			add_result <= add_sub ? add_a - add_b : add_a + add_b;
		end
	end

	//////////////////////////////
	// multiply, 4 stages
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mul_a      <= '0;
			mul_b      <= '0;
			pp_lo      <= '0;
			pp_hi      <= '0;
			mul_sum    <= '0;
			mul_result <= '0;
		end else begin
			if (mul_start) begin
				mul_a <= a;
				mul_b <= b;
			end
			pp_lo      <= prod_lo;
			pp_hi      <= prod_hi;
			mul_sum    <= pp_lo + {pp_hi, {HALF_W{1'b0}}};
			mul_result <= mul_sum;
		end
	end

endmodule

`default_nettype wire

/* hw/issue_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_stage import cdb_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  in_valid,
	output logic  in_ready,
	input  op_t   in_op,
	input  data_t in_a,
	input  data_t in_b,
	input  tag_t  in_tag,
	output logic  disp_valid,
	output unit_t disp_unit,
	output tag_t  disp_tag,
	input  logic  disp_ready,
	output op_t   op,
	output data_t a,
	output data_t b,
	output logic  add_start,
	output logic  mul_start,
	output logic  div_start
);
	logic full;
	logic accept;
	logic disp_fire;
	tag_t tag_q;

	assign disp_fire = full && disp_ready;
	// entry frees up on the same edge it dispatches
	assign in_ready  = !full || disp_fire;
	assign accept    = in_valid && in_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
		end else if (accept) begin
			full <= 1'b1;
		end else if (disp_fire) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op    <= in_op;
			a     <= in_a;
			b     <= in_b;
			tag_q <= in_tag;
		end
	end

	// opcode to unit
	always_comb begin
		case (op)
			OP_ADD, OP_SUB: disp_unit = UNIT_ADD_SUB;
			OP_MUL:         disp_unit = UNIT_MUL;
			default:        disp_unit = UNIT_DIV;
		endcase
	end

	assign disp_valid = full;
	assign disp_tag   = tag_q;

	assign add_start = disp_fire && (disp_unit == UNIT_ADD_SUB);
	assign mul_start = disp_fire && (disp_unit == UNIT_MUL);
	assign div_start = disp_fire && (disp_unit == UNIT_DIV);

endmodule

`default_nettype wire

/* hw/cdb_pkg.sv */
`default_nettype none

package cdb_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int DATA_W = 32;
	localparam int HALF_W = DATA_W / 2;
	localparam int TAG_W  = 4;

	//////////////////////////////
	// latencies, dispatch to bus
	//////////////////////////////
	localparam int ADD_LAT    = 2;
	localparam int MUL_LAT    = 4;
	// one load cycle, one quotient bit per iteration, one output cycle
	localparam int DIV_ITERS  = DATA_W;
	localparam int DIV_LAT    = DIV_ITERS + 2;
	localparam int SLOT_DEPTH = DIV_LAT;

	typedef logic [DATA_W-1:0]             data_t;
	typedef logic [TAG_W-1:0]              tag_t;
	typedef logic [$clog2(DIV_ITERS)-1:0]  div_cnt_t;
	typedef logic [$clog2(SLOT_DEPTH)-1:0] slot_idx_t;

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MUL,
		OP_DIV
	} op_t;

	// owner of a booked bus slot
	typedef enum logic [1:0] {
		UNIT_ADD_SUB,
		UNIT_MUL,
		UNIT_DIV
	} unit_t;

endpackage

`default_nettype wire
